//--- Makefile
# Verilator build and run of the decode stage testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module tb_id_stage -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
hdl/id_pkg.sv
hdl/id_ctrl_if.sv
hdl/id_decoder.sv
hdl/id_operands.sv
hdl/id_ex_pipe.sv
hdl/id_stage.sv
dv/tb_id_stage.sv

//--- dv/tb_id_stage.sv
////////////////////////////////////////
// Directed testbench for the RV32I decode stage
// Encodes instructions, drives id_stage and checks the ID/EX outputs
////////////////////////////////////////
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 50;
  localparam int HS_LIMIT        = 20;

  logic       clk;
  logic       rst_n;
  logic       instr_valid_i;
  word_t      instr_i;
  word_t      pc_i;
  logic       id_ready_o;
  logic       id_valid_o;
  logic       halt_i;
  logic       kill_i;
  fw_sel_e    fw_sel_a_i;
  fw_sel_e    fw_sel_b_i;
  reg_addr_t  rf_raddr_a_o;
  reg_addr_t  rf_raddr_b_o;
  logic [1:0] rf_re_o;
  word_t      rf_rdata_a_i;
  word_t      rf_rdata_b_i;
  word_t      rf_wdata_ex_i;
  word_t      rf_wdata_wb_i;
  logic       jmp_o;
  word_t      jmp_target_o;
  logic       ex_ready_i;
  logic       ex_valid_o;
  logic       ex_alu_en_o;
  alu_op_e    ex_alu_op_o;
  logic       ex_alu_bch_o;
  logic       ex_alu_jmp_o;
  word_t      ex_operand_a_o;
  word_t      ex_operand_b_o;
  word_t      ex_operand_c_o;
  logic       ex_lsu_en_o;
  logic       ex_lsu_we_o;
  lsu_size_e  ex_lsu_size_o;
  logic       ex_lsu_sext_o;
  logic       ex_rf_we_o;
  reg_addr_t  ex_rf_waddr_o;
  logic       ex_illegal_o;
  word_t      ex_pc_o;

  int    errors = 0;
  int    checks = 0;
  word_t lcg_state = 32'd46056;

  id_stage dut (.*);

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Bound grows with the number of tests
  initial begin : watchdog
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////
  // Random values and encoders
  ////////////////////////////////////////
  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Never x0
  function automatic reg_addr_t rand_reg();
    word_t v;
    v = lcg_next();
    return (v[31:27] == 5'd0) ? 5'd1 : v[31:27];
  endfunction

  function automatic word_t rand_pc();
    word_t v;
    v = lcg_next();
    return {v[31:2], 2'b00};
  endfunction

  function automatic logic [11:0] rand_imm12();
    word_t v;
    v = lcg_next();
    return v[27:16];
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  // Bit 0 of the offset is implied zero
  function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                  input opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic word_t sext12(input logic [11:0] x);
    return {{20{x[11]}}, x};
  endfunction

  ////////////////////////////////////////
  // Drive and check helpers
  ////////////////////////////////////////
  task automatic check(input string what, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check(what, 32'(got), 32'(exp));
  endtask

  task automatic set_regs();
    rf_rdata_a_i  = lcg_next();
    rf_rdata_b_i  = lcg_next();
    rf_wdata_ex_i = lcg_next();
    rf_wdata_wb_i = lcg_next();
  endtask

  // Called just after a falling edge, waits for the combinational outputs
  task automatic present(input word_t instr, input word_t pc);
    instr_i       = instr;
    pc_i          = pc;
    instr_valid_i = 1'b1;
    #1;
  endtask

  // Waits for the transfer, returns at the falling edge after it
  task automatic complete();
    int waited;
    waited = 0;
    while (!(id_valid_o && ex_ready_i) && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!(id_valid_o && ex_ready_i)) begin
      $display("Error at %0t: the stage never accepted the instruction", $time);
      errors++;
    end else begin
      @(negedge clk);
    end
    instr_valid_i = 1'b0;
  endtask

  task automatic expect_ex(input string name, input word_t a, input word_t b,
                           input logic we, input reg_addr_t rd);
    check_bit({name, " ex_valid"}, ex_valid_o, 1'b1);
    check({name, " operand A"}, ex_operand_a_o, a);
    check({name, " operand B"}, ex_operand_b_o, b);
    check({name, " pc"}, ex_pc_o, pc_i);
    check_bit({name, " rf_we"}, ex_rf_we_o, we);
    if (we) begin
      check({name, " rd"}, 32'(ex_rf_waddr_o), 32'(rd));
    end
  endtask

  task automatic report(input int num, input string name, input int errs_before);
    $display("Test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_alu();
    int          errs;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic [11:0] imm;
    errs = errors;
    rs1 = rand_reg();
    rs2 = rand_reg();
    rd  = rand_reg();
    set_regs();
    present(enc_r(7'b0, rs2, rs1, 3'b000, rd), rand_pc());
    // Read ports in the same cycle
    check("ADD raddr A", 32'(rf_raddr_a_o), 32'(rs1));
    check("ADD raddr B", 32'(rf_raddr_b_o), 32'(rs2));
    check("ADD rf_re", 32'(rf_re_o), 32'd3);
    complete();
    check("ADD op", 32'(ex_alu_op_o), 32'(ALU_ADD));
    check_bit("ADD alu_en", ex_alu_en_o, 1'b1);
    expect_ex("ADD", rf_rdata_a_i, rf_rdata_b_i, 1'b1, rd);
    set_regs();
    present(enc_r(7'b0100000, rs2, rs1, 3'b000, rd), rand_pc());
    complete();
    check("SUB op", 32'(ex_alu_op_o), 32'(ALU_SUB));
    expect_ex("SUB", rf_rdata_a_i, rf_rdata_b_i, 1'b1, rd);
    imm = rand_imm12();
    present(enc_i(imm, rs1, 3'b100, rd, OPC_OP_IMM), rand_pc());
    complete();
    check("XORI op", 32'(ex_alu_op_o), 32'(ALU_XOR));
    expect_ex("XORI", rf_rdata_a_i, sext12(imm), 1'b1, rd);
    // Write to x0 is dropped
    imm = rand_imm12();
    present(enc_i(imm, rs1, 3'b010, 5'd0, OPC_OP_IMM), rand_pc());
    complete();
    check("SLTI op", 32'(ex_alu_op_o), 32'(ALU_SLT));
    expect_ex("SLTI x0", rf_rdata_a_i, sext12(imm), 1'b0, 5'd0);
    report(1, "ALU operations", errs);
  endtask

  task automatic test_mem_upper();
    int          errs;
    reg_addr_t   rd;
    logic [11:0] imm;
    word_t       r;
    errs = errors;
    rd  = rand_reg();
    imm = rand_imm12();
    set_regs();
    present(enc_i(imm, rand_reg(), 3'b010, rd, OPC_LOAD), rand_pc());
    complete();
    expect_ex("LW", rf_rdata_a_i, sext12(imm), 1'b1, rd);
    check_bit("LW lsu_en", ex_lsu_en_o, 1'b1);
    check_bit("LW lsu_we", ex_lsu_we_o, 1'b0);
    check("LW size", 32'(ex_lsu_size_o), 32'(LSU_WORD));
    check_bit("LW sext", ex_lsu_sext_o, 1'b1);
    check_bit("LW alu_en", ex_alu_en_o, 1'b0);
    imm = rand_imm12();
    set_regs();
    present(enc_s(imm, rand_reg(), rand_reg(), 3'b000), rand_pc());
    complete();
    expect_ex("SB", rf_rdata_a_i, sext12(imm), 1'b0, 5'd0);
    check("SB operand C", ex_operand_c_o, rf_rdata_b_i);
    check_bit("SB lsu_we", ex_lsu_we_o, 1'b1);
    check("SB size", 32'(ex_lsu_size_o), 32'(LSU_BYTE));
    r = lcg_next();
    present(enc_u(r[31:12], rd, OPC_LUI), rand_pc());
    complete();
    expect_ex("LUI", 32'd0, {r[31:12], 12'b0}, 1'b1, rd);
    check("LUI op", 32'(ex_alu_op_o), 32'(ALU_ADD));
    r = lcg_next();
    present(enc_u(r[31:12], rd, OPC_AUIPC), rand_pc());
    complete();
    expect_ex("AUIPC", pc_i, {r[31:12], 12'b0}, 1'b1, rd);
    report(2, "loads, stores, LUI, AUIPC", errs);
  endtask

  task automatic test_branch_jump();
    int          errs;
    reg_addr_t   rd;
    logic [11:0] imm;
    word_t       r;
    errs = errors;
    rd = rand_reg();
    r  = lcg_next();
    set_regs();
    present(enc_b({r[11:0], 1'b0}, rand_reg(), rand_reg(), 3'b000), rand_pc());
    check_bit("BEQ jmp_o", jmp_o, 1'b0);
    complete();
    check("BEQ target", ex_operand_c_o, pc_i + {{19{r[11]}}, r[11:0], 1'b0});
    check("BEQ op", 32'(ex_alu_op_o), 32'(ALU_EQ));
    check_bit("BEQ alu_bch", ex_alu_bch_o, 1'b1);
    check_bit("BEQ rf_we", ex_rf_we_o, 1'b0);
    r = lcg_next();
    present(enc_j({r[19:0], 1'b0}, rd), rand_pc());
    check_bit("JAL jmp_o", jmp_o, 1'b1);
    check("JAL target", jmp_target_o, pc_i + {{11{r[19]}}, r[19:0], 1'b0});
    complete();
    expect_ex("JAL", pc_i, 32'd4, 1'b1, rd);
    check_bit("JAL alu_jmp", ex_alu_jmp_o, 1'b1);
    imm = rand_imm12();
    present(enc_i(imm, rand_reg(), 3'b000, rd, OPC_JALR), rand_pc());
    check_bit("JALR jmp_o", jmp_o, 1'b1);
    check("JALR target", jmp_target_o, (rf_rdata_a_i + sext12(imm)) & ~32'd1);
    complete();
    expect_ex("JALR", pc_i, 32'd4, 1'b1, rd);
    report(3, "branches and jumps", errs);
  endtask

  task automatic test_forwarding();
    int          errs;
    reg_addr_t   rd;
    logic [11:0] imm;
    errs = errors;
    rd = rand_reg();
    set_regs();
    fw_sel_a_i = SEL_FW_EX;
    fw_sel_b_i = SEL_FW_WB;
    present(enc_r(7'b0, rand_reg(), rand_reg(), 3'b000, rd), rand_pc());
    complete();
    expect_ex("fw EX/WB", rf_wdata_ex_i, rf_wdata_wb_i, 1'b1, rd);
    set_regs();
    fw_sel_a_i = SEL_FW_WB;
    fw_sel_b_i = SEL_FW_EX;
    present(enc_r(7'b0, rand_reg(), rand_reg(), 3'b000, rd), rand_pc());
    complete();
    expect_ex("fw WB/EX", rf_wdata_wb_i, rf_wdata_ex_i, 1'b1, rd);
    // JALR base comes from the forwarded rs1
    imm = rand_imm12();
    fw_sel_a_i = SEL_FW_EX;
    present(enc_i(imm, rand_reg(), 3'b000, rd, OPC_JALR), rand_pc());
    check("JALR fw EX target", jmp_target_o, (rf_wdata_ex_i + sext12(imm)) & ~32'd1);
    fw_sel_a_i = SEL_FW_WB;
    #1;
    check("JALR fw WB target", jmp_target_o, (rf_wdata_wb_i + sext12(imm)) & ~32'd1);
    complete();
    fw_sel_a_i = SEL_REGFILE;
    fw_sel_b_i = SEL_REGFILE;
    report(4, "forwarding", errs);
  endtask

  task automatic test_handshake();
    int          errs;
    int          k;
    word_t       held_a;
    word_t       held_pc;
    logic [11:0] imms [3];
    errs = errors;
    // Stall from EX keeps the register contents
    set_regs();
    present(enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd7), rand_pc());
    complete();
    held_a = rf_rdata_a_i;
    set_regs();
    ex_ready_i = 1'b0;
    present(enc_r(7'b0, 5'd4, 5'd3, 3'b000, 5'd8), rand_pc());
    check_bit("stall id_ready", id_ready_o, 1'b0);
    repeat (2) @(negedge clk);
    check_bit("stall ex_valid", ex_valid_o, 1'b1);
    check("stall operand A", ex_operand_a_o, held_a);
    check("stall rd", 32'(ex_rf_waddr_o), 32'd7);
    ex_ready_i = 1'b1;
    complete();
    expect_ex("after stall", rf_rdata_a_i, rf_rdata_b_i, 1'b1, 5'd8);
    // Halt blocks the stage and sends a bubble
    held_a  = rf_rdata_a_i;
    held_pc = pc_i;
    set_regs();
    halt_i  = 1'b1;
    present(enc_r(7'b0, 5'd6, 5'd5, 3'b000, 5'd9), rand_pc());
    check_bit("halt id_ready", id_ready_o, 1'b0);
    check_bit("halt id_valid", id_valid_o, 1'b0);
    @(negedge clk);
    check_bit("halt ex_valid", ex_valid_o, 1'b0);
    check("halt operand A", ex_operand_a_o, held_a);
    halt_i = 1'b0;
    kill_i = 1'b1;
    #1;
    check_bit("kill id_ready", id_ready_o, 1'b1);
    check_bit("kill id_valid", id_valid_o, 1'b0);
    @(negedge clk);
    check_bit("kill ex_valid", ex_valid_o, 1'b0);
    check("kill pc", ex_pc_o, held_pc);
    kill_i        = 1'b0;
    instr_valid_i = 1'b0;
    // One instruction per cycle, result shows one edge later
    for (k = 0; k < 4; k++) begin
      if (k > 0) begin
        check_bit("b2b ex_valid", ex_valid_o, 1'b1);
        check("b2b rd", 32'(ex_rf_waddr_o), 32'(10 + k - 1));
        check("b2b operand B", ex_operand_b_o, sext12(imms[k - 1]));
      end
      if (k < 3) begin
        imms[k] = rand_imm12();
        present(enc_i(imms[k], 5'd1, 3'b000, 5'(10 + k), OPC_OP_IMM), rand_pc());
        @(negedge clk);
      end else begin
        instr_valid_i = 1'b0;
      end
    end
    report(5, "handshake", errs);
  endtask

  task automatic test_illegal_reset();
    int    errs;
    word_t r;
    errs = errors;
    r = lcg_next();
    present({r[31:12], 5'd3, 7'b1111111}, rand_pc());
    complete();
    check_bit("illegal flag", ex_illegal_o, 1'b1);
    check_bit("illegal ex_valid", ex_valid_o, 1'b1);
    check_bit("illegal rf_we", ex_rf_we_o, 1'b0);
    check_bit("illegal lsu_en", ex_lsu_en_o, 1'b0);
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("reset ex_valid", ex_valid_o, 1'b0);
    check_bit("reset rf_we", ex_rf_we_o, 1'b0);
    check_bit("reset lsu_en", ex_lsu_en_o, 1'b0);
    check_bit("reset alu_en", ex_alu_en_o, 1'b0);
    check_bit("reset alu_bch", ex_alu_bch_o, 1'b0);
    check_bit("reset alu_jmp", ex_alu_jmp_o, 1'b0);
    check_bit("reset illegal", ex_illegal_o, 1'b0);
    check("reset operand A", ex_operand_a_o, 32'd0);
    check("reset operand B", ex_operand_b_o, 32'd0);
    check("reset operand C", ex_operand_c_o, 32'd0);
    check("reset pc", ex_pc_o, 32'd0);
    check("reset rd", 32'(ex_rf_waddr_o), 32'd0);
    check("reset alu_op", 32'(ex_alu_op_o), 32'(ALU_SLTU));
    report(6, "illegal instruction and reset", errs);
  endtask

  initial begin : main
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    halt_i        = 1'b0;
    kill_i        = 1'b0;
    fw_sel_a_i    = SEL_REGFILE;
    fw_sel_b_i    = SEL_REGFILE;
    rf_rdata_a_i  = '0;
    rf_rdata_b_i  = '0;
    rf_wdata_ex_i = '0;
    rf_wdata_wb_i = '0;
    ex_ready_i    = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_alu();
    test_mem_upper();
    test_branch_jump();
    test_forwarding();
    test_handshake();
    test_illegal_reset();
    $display("Tests run: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/id_ctrl_if.sv
////////////////////////////////////////
// Decoded control bundle of the decode stage
// Driven by the decoder, read by operand logic and ID/EX register
////////////////////////////////////////
`default_nettype none

interface id_ctrl_if import id_pkg::*; ();

  alu_op_e   alu_op;
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  op_c_sel_e op_c_sel;
  imm_sel_e  imm_sel;
  logic      lsu_en;
  logic      lsu_we;
  lsu_size_e lsu_size;
  logic      lsu_sext;
  logic      rf_we;
  logic      alu_bch;
  logic      alu_jmp;
  logic      alu_jmpr;
  logic      illegal;

  // Decoder side, all combinational from the instruction
  modport dec (
    output alu_op, op_a_sel, op_b_sel, op_c_sel, imm_sel,
    output lsu_en, lsu_we, lsu_size, lsu_sext,
    output rf_we, alu_bch, alu_jmp, alu_jmpr, illegal
  );

  // Operand muxes and target adders
  modport opr (input op_a_sel, op_b_sel, op_c_sel, imm_sel, alu_jmpr);

  // ID/EX register
  modport pipe (
    input alu_op, op_c_sel, lsu_en, lsu_we, lsu_size, lsu_sext,
    input rf_we, alu_bch, alu_jmp, illegal
  );

endinterface

`default_nettype wire

//--- hdl/id_decoder.sv
////////////////////////////////////////
// RV32I base decoder
// Turns opcode and funct fields into stage control
////////////////////////////////////////
`default_nettype none

module id_decoder import id_pkg::*; (
  input  word_t      instr_i,
  output logic [1:0] rf_re_o,
  id_ctrl_if.dec     ctrl
);

  opcode_e   opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t rd;

  // Shared arithmetic decode for OP and OP_IMM
  logic      arith_alt;
  alu_op_e   arith_op;

  assign opcode = opcode_e'(instr_i[OPCODE_LSB +: 7]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd     = instr_i[RD_LSB +: 5];

  // Bit 30 picks SUB and SRA, OP_IMM only has SRAI
  assign arith_alt = funct7[5] && (opcode == OPC_OP || funct3 == 3'b101);

  always_comb begin : arith_decode
    unique case (funct3)
      3'b000:  arith_op = arith_alt ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = arith_alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin : main_decode
    // Defaults describe a no-op
    ctrl.alu_op   = ALU_SLTU;
    ctrl.op_a_sel = OP_A_REG;
    ctrl.op_b_sel = OP_B_REG;
    ctrl.op_c_sel = OP_C_REG;
    ctrl.imm_sel  = IMM_I;
    ctrl.lsu_en   = 1'b0;
    ctrl.lsu_we   = 1'b0;
    ctrl.lsu_size = LSU_WORD;
    ctrl.lsu_sext = 1'b0;
    ctrl.rf_we    = 1'b0;
    ctrl.alu_bch  = 1'b0;
    ctrl.alu_jmp  = 1'b0;
    ctrl.alu_jmpr = 1'b0;
    ctrl.illegal  = 1'b0;
    rf_re_o       = 2'b00;

    case (opcode)
      OPC_OP: begin
        ctrl.alu_op = arith_op;
        ctrl.rf_we  = 1'b1;
        rf_re_o     = 2'b11;
        // Only ADD/SUB and SRL/SRA have an alternate funct7
        if (funct7 != 7'b0 &&
            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          ctrl.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        ctrl.alu_op   = arith_op;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.rf_we    = 1'b1;
        rf_re_o       = 2'b01;
        // Shift amounts are 5 bits, upper funct7 must be clean
        if (funct3 == 3'b001 && funct7 != 7'b0) begin
          ctrl.illegal = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != 7'b0 && funct7 != 7'b0100000) begin
          ctrl.illegal = 1'b1;
        end
      end
      OPC_LUI, OPC_AUIPC: begin
        ctrl.alu_op   = ALU_ADD;
        ctrl.op_a_sel = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_U;
        ctrl.rf_we    = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_size = lsu_size_e'(funct3[1:0]);
        ctrl.lsu_sext = !funct3[2];
        ctrl.rf_we    = 1'b1;
        rf_re_o       = 2'b01;
        // LB LH LW LBU LHU
        if (funct3[1:0] == 2'b11 || funct3 == 3'b110) begin
          ctrl.illegal = 1'b1;
        end
      end
      OPC_STORE: begin
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_S;
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_we   = 1'b1;
        ctrl.lsu_size = lsu_size_e'(funct3[1:0]);
        rf_re_o       = 2'b11;
        if (funct3[2] || funct3[1:0] == 2'b11) begin
          ctrl.illegal = 1'b1;
        end
      end
      OPC_BRANCH: begin
        ctrl.op_c_sel = OP_C_BCH;
        ctrl.imm_sel  = IMM_B;
        ctrl.alu_bch  = 1'b1;
        rf_re_o       = 2'b11;
        unique case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      OPC_JAL, OPC_JALR: begin
        // Link value PC + 4 is computed in the ALU
        ctrl.alu_op   = ALU_ADD;
        ctrl.op_a_sel = OP_A_PC;
        ctrl.op_b_sel = OP_B_PCINCR;
        ctrl.imm_sel  = (opcode == OPC_JAL) ? IMM_J : IMM_I;
        ctrl.rf_we    = 1'b1;
        ctrl.alu_jmp  = 1'b1;
        ctrl.alu_jmpr = (opcode == OPC_JALR);
        rf_re_o       = (opcode == OPC_JALR) ? 2'b01 : 2'b00;
        if (opcode == OPC_JALR && funct3 != 3'b000) begin
          ctrl.illegal = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // Illegal instructions travel with no side effects
    if (ctrl.illegal) begin
      ctrl.rf_we    = 1'b0;
      ctrl.lsu_en   = 1'b0;
      ctrl.lsu_we   = 1'b0;
      ctrl.alu_bch  = 1'b0;
      ctrl.alu_jmp  = 1'b0;
      ctrl.alu_jmpr = 1'b0;
      rf_re_o       = 2'b00;
    end

    // Writes to x0 are dropped here
    if (rd == 5'd0) begin
      ctrl.rf_we = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/id_ex_pipe.sv
////////////////////////////////////////
// ID/EX register with stage valid/ready
// Fields load only where the instruction uses them
////////////////////////////////////////
`default_nettype none

module id_ex_pipe import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      instr_valid_i,
  input  logic      halt_i,
  input  logic      kill_i,
  input  logic      ex_ready_i,
  input  word_t     instr_i,
  input  word_t     pc_i,
  input  word_t     operand_a_i,
  input  word_t     operand_b_i,
  input  word_t     operand_c_i,
  id_ctrl_if.pipe   ctrl,
  output logic      id_ready_o,
  output logic      id_valid_o,
  output logic      ex_valid_o,
  output logic      ex_alu_en_o,
  output alu_op_e   ex_alu_op_o,
  output logic      ex_alu_bch_o,
  output logic      ex_alu_jmp_o,
  output word_t     ex_operand_a_o,
  output word_t     ex_operand_b_o,
  output word_t     ex_operand_c_o,
  output logic      ex_lsu_en_o,
  output logic      ex_lsu_we_o,
  output lsu_size_e ex_lsu_size_o,
  output logic      ex_lsu_sext_o,
  output logic      ex_rf_we_o,
  output reg_addr_t ex_rf_waddr_o,
  output logic      ex_illegal_o,
  output word_t     ex_pc_o
);

  logic alu_en;
  logic op_c_used;

  // Halt blocks both directions, kill drops the instruction
  assign id_valid_o = instr_valid_i && !kill_i && !halt_i;
  assign id_ready_o = kill_i || (ex_ready_i && !halt_i);

  // Loads and stores compute their address in the LSU
  assign alu_en = !ctrl.illegal && !ctrl.lsu_en;

  // Stores need rs2, branches need the target
  assign op_c_used = !ctrl.illegal && (ctrl.lsu_we || ctrl.op_c_sel == OP_C_BCH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o     <= 1'b0;
      ex_alu_en_o    <= 1'b0;
      ex_alu_op_o    <= ALU_SLTU;
      ex_alu_bch_o   <= 1'b0;
      ex_alu_jmp_o   <= 1'b0;
      ex_operand_a_o <= '0;
      ex_operand_b_o <= '0;
      ex_operand_c_o <= '0;
      ex_lsu_en_o    <= 1'b0;
      ex_lsu_we_o    <= 1'b0;
      ex_lsu_size_o  <= LSU_BYTE;
      ex_lsu_sext_o  <= 1'b0;
      ex_rf_we_o     <= 1'b0;
      ex_rf_waddr_o  <= '0;
      ex_illegal_o   <= 1'b0;
      ex_pc_o        <= '0;
    end else if (id_valid_o && ex_ready_i) begin
      ex_valid_o   <= 1'b1;
      ex_illegal_o <= ctrl.illegal;
      ex_pc_o      <= pc_i;

      // Every legal instruction reads A and B
      if (!ctrl.illegal) begin
        ex_operand_a_o <= operand_a_i;
        ex_operand_b_o <= operand_b_i;
      end
      if (op_c_used) begin
        ex_operand_c_o <= operand_c_i;
      end

      ex_alu_en_o <= alu_en;
      if (alu_en) begin
        ex_alu_op_o  <= ctrl.alu_op;
        ex_alu_bch_o <= ctrl.alu_bch;
        ex_alu_jmp_o <= ctrl.alu_jmp;
      end

      ex_lsu_en_o <= ctrl.lsu_en;
      if (ctrl.lsu_en) begin
        ex_lsu_we_o   <= ctrl.lsu_we;
        ex_lsu_size_o <= ctrl.lsu_size;
        ex_lsu_sext_o <= ctrl.lsu_sext;
      end

      ex_rf_we_o <= ctrl.rf_we;
      if (ctrl.rf_we) begin
        ex_rf_waddr_o <= instr_i[RD_LSB +: 5];
      end
    end else if (ex_ready_i) begin
      // Bubble into EX, payload holds
      ex_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/id_operands.sv
////////////////////////////////////////
// Immediates, forwarding and operand muxes
// Also builds branch and jump targets, all combinational
////////////////////////////////////////
`default_nettype none

module id_operands import id_pkg::*; (
  input  word_t   instr_i,
  input  word_t   pc_i,
  input  word_t   rf_rdata_a_i,
  input  word_t   rf_rdata_b_i,
  input  word_t   rf_wdata_ex_i,
  input  word_t   rf_wdata_wb_i,
  input  fw_sel_e fw_sel_a_i,
  input  fw_sel_e fw_sel_b_i,
  output word_t   operand_a_o,
  output word_t   operand_b_o,
  output word_t   operand_c_o,
  output word_t   jmp_target_o,
  id_ctrl_if.opr  ctrl
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t imm;
  word_t rs1_fw;
  word_t rs2_fw;
  word_t bch_target;
  word_t jalr_sum;

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////
  // All sign extended from bit 31
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin : imm_mux
    case (ctrl.imm_sel)
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_U:   imm = imm_u;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

  ////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////
  always_comb begin : rs1_fw_mux
    case (fw_sel_a_i)
      SEL_FW_EX: rs1_fw = rf_wdata_ex_i;
      SEL_FW_WB: rs1_fw = rf_wdata_wb_i;
      default:   rs1_fw = rf_rdata_a_i;
    endcase
  end

  always_comb begin : rs2_fw_mux
    case (fw_sel_b_i)
      SEL_FW_EX: rs2_fw = rf_wdata_ex_i;
      SEL_FW_WB: rs2_fw = rf_wdata_wb_i;
      default:   rs2_fw = rf_rdata_b_i;
    endcase
  end

  ////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////
  always_comb begin : op_a_mux
    case (ctrl.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_fw;
    endcase
  end

  always_comb begin : op_b_mux
    case (ctrl.op_b_sel)
      OP_B_IMM:    operand_b_o = imm;
      OP_B_PCINCR: operand_b_o = 32'd4;
      default:     operand_b_o = rs2_fw;
    endcase
  end

  // Branch target rides to EX on operand C
  assign bch_target  = pc_i + imm_b;
  assign operand_c_o = (ctrl.op_c_sel == OP_C_BCH) ? bch_target : rs2_fw;

  // JALR clears bit 0 of the sum
  assign jalr_sum     = rs1_fw + imm_i;
  assign jmp_target_o = ctrl.alu_jmpr ? {jalr_sum[31:1], 1'b0} : pc_i + imm_j;

endmodule

`default_nettype wire

//--- hdl/id_pkg.sv
////////////////////////////////////////
// Shared types and field positions for the RV32I decode stage
// Imported by every module of the stage
////////////////////////////////////////
`default_nettype none

package id_pkg;

  // Field positions in the instruction word
  localparam int unsigned OPCODE_LSB = 0;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned RS2_LSB    = 20;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes, low two bits always 11
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  ////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////
  // Arithmetic first, then the branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  ////////////////////////////////////////
  // Mux selects
  ////////////////////////////////////////
  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;

  // PCINCR gives the link offset of 4
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;

  // Forwarded rs2 for stores, branch target for branches
  typedef enum logic {OP_C_REG, OP_C_BCH} op_c_sel_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  // Operand source chosen by the controller
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;

  // Encoded as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;

endpackage

`default_nettype wire

//--- hdl/id_stage.sv
////////////////////////////////////////
// Top of the RV32I decode stage
// Connects decoder, operand logic and ID/EX register
////////////////////////////////////////
`default_nettype none

module id_stage import id_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // Fetch side
  input  logic       instr_valid_i,
  input  word_t      instr_i,
  input  word_t      pc_i,
  output logic       id_ready_o,
  output logic       id_valid_o,

  // Controller
  input  logic       halt_i,
  input  logic       kill_i,
  input  fw_sel_e    fw_sel_a_i,
  input  fw_sel_e    fw_sel_b_i,

  // Register file and forwarding sources
  output reg_addr_t  rf_raddr_a_o,
  output reg_addr_t  rf_raddr_b_o,
  output logic [1:0] rf_re_o,
  input  word_t      rf_rdata_a_i,
  input  word_t      rf_rdata_b_i,
  input  word_t      rf_wdata_ex_i,
  input  word_t      rf_wdata_wb_i,

  // Jumps resolved in ID
  output logic       jmp_o,
  output word_t      jmp_target_o,

  // EX side
  input  logic       ex_ready_i,
  output logic       ex_valid_o,
  output logic       ex_alu_en_o,
  output alu_op_e    ex_alu_op_o,
  output logic       ex_alu_bch_o,
  output logic       ex_alu_jmp_o,
  output word_t      ex_operand_a_o,
  output word_t      ex_operand_b_o,
  output word_t      ex_operand_c_o,
  output logic       ex_lsu_en_o,
  output logic       ex_lsu_we_o,
  output lsu_size_e  ex_lsu_size_o,
  output logic       ex_lsu_sext_o,
  output logic       ex_rf_we_o,
  output reg_addr_t  ex_rf_waddr_o,
  output logic       ex_illegal_o,
  output word_t      ex_pc_o
);

  word_t operand_a;
  word_t operand_b;
  word_t operand_c;

  id_ctrl_if ctrl ();

  // Read addresses straight from the instruction
  assign rf_raddr_a_o = instr_i[RS1_LSB +: 5];
  assign rf_raddr_b_o = instr_i[RS2_LSB +: 5];

  // Fetch redirect only for an instruction that leaves ID
  assign jmp_o = ctrl.alu_jmp && id_valid_o;

  id_decoder u_decoder (
    .instr_i (instr_i),
    .rf_re_o (rf_re_o),
    .ctrl    (ctrl)
  );

  id_operands u_operands (
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .fw_sel_a_i    (fw_sel_a_i),
    .fw_sel_b_i    (fw_sel_b_i),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c),
    .jmp_target_o  (jmp_target_o),
    .ctrl          (ctrl)
  );

  id_ex_pipe u_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .halt_i         (halt_i),
    .kill_i         (kill_i),
    .ex_ready_i     (ex_ready_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .operand_c_i    (operand_c),
    .ctrl           (ctrl),
    .id_ready_o     (id_ready_o),
    .id_valid_o     (id_valid_o),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_en_o    (ex_alu_en_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_alu_bch_o   (ex_alu_bch_o),
    .ex_alu_jmp_o   (ex_alu_jmp_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_operand_c_o (ex_operand_c_o),
    .ex_lsu_en_o    (ex_lsu_en_o),
    .ex_lsu_we_o    (ex_lsu_we_o),
    .ex_lsu_size_o  (ex_lsu_size_o),
    .ex_lsu_sext_o  (ex_lsu_sext_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_rf_waddr_o  (ex_rf_waddr_o),
    .ex_illegal_o   (ex_illegal_o),
    .ex_pc_o        (ex_pc_o)
  );

endmodule

`default_nettype wire
